// ==== build.f ====
+incdir+verification
src/bch_pkg.sv
src/byte_intake.sv
src/syndrome_horner_cell.sv
src/syndrome_accum.sv
src/syndrome_report.sv
src/bch_syndrome_top.sv
verification/tb_bch_syndrome.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the BCH syndrome testbench with Verilator, runs it and checks the log for a pass
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_bch_syndrome -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "RESULT: PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== verification/tb_gf_model.svh ====
// GF(2^8) reference arithmetic and BCH syndrome model, included inside the testbench module
`ifndef TB_GF_MODEL_SVH
`define TB_GF_MODEL_SVH

typedef logic [7:0] byte_q_t [$];

// Carry-less multiply, reduced by x^8+x^4+x^3+x^2+1 whenever bit 8 appears
function automatic logic [7:0] model_mul(input logic [7:0] a, input logic [7:0] b);
	logic [8:0] shifted;
	logic [7:0] prod;
	shifted = {1'b0, a};
	prod = 8'h00;
	for (int i = 0; i < 8; i++) begin
		if (b[i]) begin
			prod = prod ^ shifted[7:0];
		end
		shifted = shifted << 1;
		if (shifted[8]) begin
			shifted = shifted ^ 9'h11d;
		end
	end
	return prod;
endfunction

// Nonzero elements form a group of order 255
function automatic logic [7:0] model_pow(input logic [7:0] base, input int e);
	logic [7:0] r;
	r = 8'h01;
	for (int i = 0; i < e % 255; i++) begin
		r = model_mul(r, base);
	end
	return r;
endfunction

// S_j = r(alpha^j), one bit at a time in arrival order, bit 0 of each byte first
function automatic logic [7:0] model_syndrome(input byte_q_t bytes, input int j);
	logic [7:0] aj;
	logic [7:0] s;
	aj = model_pow(8'h02, j);
	s = 8'h00;
	foreach (bytes[n]) begin
		for (int k = 0; k < 8; k++) begin
			s = model_mul(s, aj) ^ {7'b0, bytes[n][k]};
		end
	end
	return s;
endfunction

`endif

// ==== verification/tb_bch_syndrome.sv ====
// Self-checking testbench for the BCH(255,239) syndrome unit and top module of the simulation
`timescale 1ns/1ps

module tb_bch_syndrome;
	import bch_pkg::*;

	`include "tb_gf_model.svh"

	typedef enum int {
		kind_zero,
		kind_single,
		kind_random,
		kind_pattern
	} kind_t;

	localparam int num_tests = 10;
	localparam int reset_cycles = 16;

	logic clk;
	logic rstn;
	logic in_req;
	logic [byte_width-1:0] in_data;
	logic in_last;
	logic in_ack;
	logic out_req;
	logic out_ack;
	gf_elem_t out_syn_1;
	gf_elem_t out_syn_2;
	gf_elem_t out_syn_3;
	gf_elem_t out_syn_4;
	logic out_err_detect;

	// Test table filled once before reset is released
	string t_name [num_tests];
	int t_bytes [num_tests];
	kind_t t_kind [num_tests];
	int t_pos [num_tests];
	int t_delay [num_tests];
	int n_added = 0;

	gf_elem_t exp_syn [num_tests][num_syndromes];
	logic exp_err [num_tests];
	byte_q_t stream;

	int results_seen = 0;
	int pass_count = 0;
	int fail_count = 0;
	int protocol_errors = 0;
	int reset_errors = 0;
	int cycle_limit;
	logic prev_req = 1'b0;
	logic prev_ack = 1'b0;
	logic result_open = 1'b0;

	bch_syndrome_top dut0 (.*);

	always #2 clk = ~clk;

	task automatic add_test(input string name, input int nbytes, input kind_t kind,
		input int pos, input int delay);
		t_name[n_added] = name;
		t_bytes[n_added] = nbytes;
		t_kind[n_added] = kind;
		t_pos[n_added] = pos;
		t_delay[n_added] = delay;
		n_added++;
	endtask

	// pos counts stream bits from the first one received
	task automatic build_stream(input int t);
		logic [7:0] b;
		stream.delete();
		for (int i = 0; i < t_bytes[t]; i++) begin
			case (t_kind[t])
				kind_random: b = 8'($urandom);
				kind_pattern: b = 8'(i * 37 + 90);
				kind_single: b = (i == t_pos[t] / 8) ? 8'(1 << (t_pos[t] % 8)) : 8'h00;
				default: b = 8'h00;
			endcase
			stream.push_back(b);
		end
	endtask

	task automatic set_expected(input int t);
		int e;
		// Degree of the single bit counted from the end of the stream
		e = t_bytes[t] * byte_width - 1 - t_pos[t];
		for (int j = 1; j <= num_syndromes; j++) begin
			if (t_kind[t] == kind_single) begin
				exp_syn[t][j-1] = model_pow(8'h02, (j * e) % 255);
			end else begin
				exp_syn[t][j-1] = model_syndrome(stream, j);
			end
		end
		exp_err[t] = |{exp_syn[t][0], exp_syn[t][1], exp_syn[t][2], exp_syn[t][3]};
	endtask

	task automatic send_byte(input logic [7:0] data, input logic last);
		in_req = 1'b1;
		in_data = data;
		in_last = last;
		while (in_ack !== 1'b1) begin
			@(posedge clk);
			#1;
		end
		// Source keeps req up one cycle past ack
		@(posedge clk);
		#1;
		in_req = 1'b0;
		while (in_ack !== 1'b0) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		in_req = 1'b0;
		in_data = '0;
		in_last = 1'b0;
		out_ack = 1'b0;
		void'($urandom(32'h9cb1044e));
		add_test("zero_32", 32, kind_zero, 0, 2);
		add_test("single_first", 32, kind_single, 0, 0);
		add_test("single_mid", 32, kind_single, 100, 3);
		add_test("single_last", 4, kind_single, 31, 1);
		add_test("random_a", 32, kind_random, 0, 1);
		add_test("random_b", 32, kind_random, 0, 0);
		add_test("pattern_16", 16, kind_pattern, 0, 2);
		add_test("backpressure", 32, kind_random, 0, 10);
		add_test("after_backpressure", 8, kind_random, 0, 0);
		add_test("one_byte", 1, kind_pattern, 0, 0);
		repeat (reset_cycles) @(posedge clk);
		#1;
		rstn = 1'b1;
		assert (in_ack === 1'b0 && out_req === 1'b0) else begin
			$display("After reset in_ack or out_req was not low");
			reset_errors++;
		end
		for (int t = 0; t < num_tests; t++) begin
			build_stream(t);
			set_expected(t);
			for (int i = 0; i < t_bytes[t]; i++) begin
				send_byte(stream[i], i == t_bytes[t] - 1);
			end
		end
		while (results_seen < num_tests) begin
			@(posedge clk);
			#1;
		end
		$display("Summary: %0d passed, %0d failed, %0d protocol errors, %0d reset errors",
			pass_count, fail_count, protocol_errors, reset_errors);
		if (fail_count == 0 && protocol_errors == 0 && reset_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Sink takes results back in codeword order
	initial begin : sink
		gf_elem_t got [num_syndromes];
		logic ok;
		wait (rstn === 1'b1);
		for (int r = 0; r < num_tests; r++) begin
			while (out_req !== 1'b1) begin
				@(posedge clk);
				#1;
			end
			repeat (t_delay[r]) begin
				@(posedge clk);
				#1;
			end
			got[0] = out_syn_1;
			got[1] = out_syn_2;
			got[2] = out_syn_3;
			got[3] = out_syn_4;
			ok = 1'b1;
			for (int j = 0; j < num_syndromes; j++) begin
				assert (got[j] === exp_syn[r][j]) else begin
					$display("Error: %s S%0d expected %02h actual %02h", t_name[r], j + 1,
						exp_syn[r][j], got[j]);
					ok = 1'b0;
				end
			end
			assert (out_err_detect === exp_err[r]) else begin
				$display("Error: %s err_detect expected %0b actual %0b", t_name[r],
					exp_err[r], out_err_detect);
				ok = 1'b0;
			end
			if (ok) begin
				pass_count++;
			end else begin
				fail_count++;
			end
			$display("%s: %s", t_name[r], ok ? "pass" : "fail");
			out_ack = 1'b1;
			while (out_req !== 1'b0) begin
				@(posedge clk);
				#1;
			end
			out_ack = 1'b0;
			results_seen++;
		end
	end

	// Four-phase order and back-pressure checks sampled mid-cycle
	always @(negedge clk) begin
		if (rstn === 1'b1) begin
			if (in_ack && !prev_ack) begin
				assert (prev_req) else begin
					$display("in_ack rose while in_req was low");
					protocol_errors++;
				end
				assert (!result_open) else begin
					$display("A byte was acknowledged while a result handshake was open");
					protocol_errors++;
				end
			end
			if (!in_ack && prev_ack) begin
				assert (!prev_req) else begin
					$display("in_ack fell while in_req was still high");
					protocol_errors++;
				end
			end
			if (out_req) begin
				result_open = 1'b1;
			end else if (!out_ack) begin
				result_open = 1'b0;
			end
		end
		prev_req = in_req;
		prev_ack = in_ack;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (rstn === 1'b1);
		cycle_limit = 0;
		for (int t = 0; t < num_tests; t++) begin
			cycle_limit += t_bytes[t] * 6 + t_delay[t] + 20;
		end
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== src/bch_syndrome_top.sv ====
// Top level of the BCH(255,239) syndrome unit, chaining intake, accumulation and report
`timescale 1ns/1ps

module bch_syndrome_top (
	input  logic clk,
	input  logic rstn,
	input  logic in_req,
	input  logic [bch_pkg::byte_width-1:0] in_data,
	input  logic in_last,
	output logic in_ack,
	output logic out_req,
	input  logic out_ack,
	output bch_pkg::gf_elem_t out_syn_1,
	output bch_pkg::gf_elem_t out_syn_2,
	output bch_pkg::gf_elem_t out_syn_3,
	output bch_pkg::gf_elem_t out_syn_4,
	output logic out_err_detect
);
	import bch_pkg::*;

	logic byte_strobe;
	logic [byte_width-1:0] byte_data;
	logic byte_last;
	gf_elem_t syn_1;
	gf_elem_t syn_2;
	gf_elem_t syn_3;
	gf_elem_t syn_4;
	logic syn_done;
	logic report_busy;

	byte_intake u_intake (
		.clk(clk),
		.rstn(rstn),
		.in_req(in_req),
		.in_data(in_data),
		.in_last(in_last),
		.report_busy(report_busy),
		.in_ack(in_ack),
		.byte_strobe(byte_strobe),
		.byte_data(byte_data),
		.byte_last(byte_last)
	);

	syndrome_accum u_accum (
		.clk(clk),
		.rstn(rstn),
		.byte_strobe(byte_strobe),
		.byte_data(byte_data),
		.byte_last(byte_last),
		.syn_1(syn_1),
		.syn_2(syn_2),
		.syn_3(syn_3),
		.syn_4(syn_4),
		.syn_done(syn_done)
	);

	// report_busy closes the loop back to intake for back-pressure
	syndrome_report u_report (
		.clk(clk),
		.rstn(rstn),
		.syn_1(syn_1),
		.syn_2(syn_2),
		.syn_3(syn_3),
		.syn_4(syn_4),
		.syn_done(syn_done),
		.out_ack(out_ack),
		.report_busy(report_busy),
		.out_req(out_req),
		.out_syn_1(out_syn_1),
		.out_syn_2(out_syn_2),
		.out_syn_3(out_syn_3),
		.out_syn_4(out_syn_4),
		.out_err_detect(out_err_detect)
	);

endmodule

// ==== src/syndrome_report.sv ====
// Output stage that holds the final syndromes and hands them out by four-phase req/ack
`timescale 1ns/1ps

module syndrome_report (
	input  logic clk,
	input  logic rstn,
	input  bch_pkg::gf_elem_t syn_1,
	input  bch_pkg::gf_elem_t syn_2,
	input  bch_pkg::gf_elem_t syn_3,
	input  bch_pkg::gf_elem_t syn_4,
	input  logic syn_done,
	input  logic out_ack,
	output logic report_busy,
	output logic out_req,
	output bch_pkg::gf_elem_t out_syn_1,
	output bch_pkg::gf_elem_t out_syn_2,
	output bch_pkg::gf_elem_t out_syn_3,
	output bch_pkg::gf_elem_t out_syn_4,
	output logic out_err_detect
);
	import bch_pkg::*;

	report_state_t state;

	// Busy from the done pulse itself so no byte slips in before the latch
	assign report_busy = syn_done || (state != report_idle);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= report_idle;
			out_req <= 1'b0;
			out_syn_1 <= '0;
			out_syn_2 <= '0;
			out_syn_3 <= '0;
			out_syn_4 <= '0;
			out_err_detect <= 1'b0;
		end else begin
			case (state)
				report_idle: begin
					if (syn_done) begin
						out_syn_1 <= syn_1;
						out_syn_2 <= syn_2;
						out_syn_3 <= syn_3;
						out_syn_4 <= syn_4;
						// Any nonzero syndrome means the word is not a codeword
						out_err_detect <= |{syn_1, syn_2, syn_3, syn_4};
						out_req <= 1'b1;
						state <= report_req;
					end
				end
				report_req: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= report_release;
					end
				end
				report_release: begin
					if (!out_ack) begin
						state <= report_idle;
					end
				end
				default: begin
					out_req <= 1'b0;
					state <= report_idle;
				end
			endcase
		end
	end

	a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
		out_req |=> (!out_req ||
			$stable({out_syn_1, out_syn_2, out_syn_3, out_syn_4, out_err_detect})));

endmodule

// ==== src/syndrome_accum.sv ====
// Accumulation stage with one Horner cell per syndrome and codeword start and end control
`timescale 1ns/1ps

module syndrome_accum (
	input  logic clk,
	input  logic rstn,
	input  logic byte_strobe,
	input  logic [bch_pkg::byte_width-1:0] byte_data,
	input  logic byte_last,
	output bch_pkg::gf_elem_t syn_1,
	output bch_pkg::gf_elem_t syn_2,
	output bch_pkg::gf_elem_t syn_3,
	output bch_pkg::gf_elem_t syn_4,
	output logic syn_done
);
	import bch_pkg::*;

	gf_elem_t syn_vec [num_syndromes];
	logic fresh;

	for (genvar i = 0; i < num_syndromes; i++) begin : g_cell
		syndrome_horner_cell #(
			.syn_index(i + 1)
		) u_cell (
			.clk(clk),
			.rstn(rstn),
			.byte_strobe(byte_strobe),
			.fresh(fresh),
			.byte_data(byte_data),
			.syn(syn_vec[i])
		);
	end

	assign syn_1 = syn_vec[0];
	assign syn_2 = syn_vec[1];
	assign syn_3 = syn_vec[2];
	assign syn_4 = syn_vec[3];

	// The strobe after a last byte opens the next codeword
	always_ff @(posedge clk) begin
		if (!rstn) begin
			fresh <= 1'b1;
			syn_done <= 1'b0;
		end else begin
			syn_done <= byte_strobe && byte_last;
			if (byte_strobe) begin
				fresh <= byte_last;
			end
		end
	end

	// relies on the intake spacing transfers by at least one idle cycle
	a_done_no_strobe: assert property (@(posedge clk) disable iff (!rstn)
		!(syn_done && byte_strobe));

endmodule

// ==== src/syndrome_horner_cell.sv ====
// Horner accumulator for one syndrome S_j over GF(2^8), eight received bits per step
`timescale 1ns/1ps

module syndrome_horner_cell #(
	parameter int syn_index = 1
) (
	input  logic clk,
	input  logic rstn,
	input  logic byte_strobe,
	input  logic fresh,
	input  logic [bch_pkg::byte_width-1:0] byte_data,
	output bch_pkg::gf_elem_t syn
);
	import bch_pkg::*;

	// Shift by one byte of degree, alpha^(8j)
	localparam gf_elem_t step = gf_alpha_pow(byte_width * syn_index);

	gf_elem_t terms [byte_width];
	gf_elem_t held;
	gf_elem_t syn_next;

	// Bit 0 arrives first so it has the highest degree within the byte
	for (genvar k = 0; k < byte_width; k++) begin : g_tap
		localparam gf_elem_t tap = gf_alpha_pow(syn_index * (byte_width - 1 - k));
		assign terms[k] = byte_data[k] ? tap : '0;
	end

	// Old value counts as zero on the first byte of a codeword
	assign held = fresh ? '0 : syn;

	always_comb begin
		syn_next = gf_mul_const(held, step);
		for (int k = 0; k < byte_width; k++) begin
			syn_next = syn_next ^ terms[k];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			syn <= '0;
		end else if (byte_strobe) begin
			syn <= syn_next;
		end
	end

endmodule

// ==== src/byte_intake.sv ====
// Input stage that accepts one byte per four-phase req/ack transfer and strobes it downstream
`timescale 1ns/1ps

module byte_intake (
	input  logic clk,
	input  logic rstn,
	input  logic in_req,
	input  logic [bch_pkg::byte_width-1:0] in_data,
	input  logic in_last,
	input  logic report_busy,
	output logic in_ack,
	output logic byte_strobe,
	output logic [bch_pkg::byte_width-1:0] byte_data,
	output logic byte_last
);
	import bch_pkg::*;

	intake_state_t state;
	logic take;

	// A new transfer is taken only once the previous result has left
	assign take = in_req && !report_busy && (state != intake_ack);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= intake_idle;
			in_ack <= 1'b0;
			byte_strobe <= 1'b0;
		end else begin
			byte_strobe <= 1'b0;
			case (state)
				intake_idle, intake_stall: begin
					if (take) begin
						state <= intake_ack;
						in_ack <= 1'b1;
						byte_strobe <= 1'b1;
					end else if (in_req) begin
						state <= intake_stall;
					end else begin
						state <= intake_idle;
					end
				end
				intake_ack: begin
					// Hold ack until the source releases req
					if (!in_req) begin
						state <= intake_idle;
						in_ack <= 1'b0;
					end
				end
				default: begin
					state <= intake_idle;
					in_ack <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			byte_data <= in_data;
			byte_last <= in_last;
		end
	end

	a_single_strobe: assert property (@(posedge clk) disable iff (!rstn)
		byte_strobe |=> !byte_strobe);

endmodule

// ==== src/bch_pkg.sv ====
// Shared field constants, FSM state types and GF(2^8) helpers, imported by every RTL stage
package bch_pkg;

	localparam int gf_width = 8;
	// Low bits of x^8+x^4+x^3+x^2+1, the x^8 term is implied
	localparam logic [gf_width-1:0] gf_poly = 8'h1d;
	localparam int gf_order = (1 << gf_width) - 1;
	localparam int byte_width = 8;
	localparam int num_syndromes = 4;

	typedef logic [gf_width-1:0] gf_elem_t;

	typedef enum logic [1:0] {
		intake_idle,
		intake_ack,
		intake_stall
	} intake_state_t;

	typedef enum logic [1:0] {
		report_idle,
		report_req,
		report_release
	} report_state_t;

	// Multiply by alpha = x, reduce on overflow of the top bit
	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t a);
		gf_elem_t r;
		r = {a[gf_width-2:0], 1'b0};
		if (a[gf_width-1]) begin
			r = r ^ gf_poly;
		end
		return r;
	endfunction

	// Meant for constant arguments, evaluated at elaboration
	function automatic gf_elem_t gf_alpha_pow(input int e);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < e % gf_order; i++) begin
			r = gf_mul_alpha(r);
		end
		return r;
	endfunction

	// Shift and reduce, MSB of the constant first
	function automatic gf_elem_t gf_mul_const(input gf_elem_t a, input gf_elem_t c);
		gf_elem_t r;
		r = '0;
		for (int i = gf_width - 1; i >= 0; i--) begin
			r = gf_mul_alpha(r);
			if (c[i]) begin
				r = r ^ a;
			end
		end
		return r;
	endfunction

endpackage
